// File: llc_hit_miss.f
+incdir+.
llc_hit_miss_pkg.sv
llc_tag_store.sv
llc_miss_counters.sv
llc_lock_table.sv
llc_hit_miss.sv
tb_llc_hit_miss.sv

// File: llc_hit_miss.sv
// hit/miss stage of the last-level cache, top level
// looks up each descriptor and sends it to the hit bypass or the miss pipeline
`timescale 1ns/1ps
`include "llc_hit_miss_macros.svh"

module llc_hit_miss import llc_hit_miss_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  llc_desc_t desc_i,
  input  logic      valid_i,
  output logic      ready_o,
  output llc_desc_t desc_o,
  output logic      hit_valid_o,
  input  logic      hit_ready_i,
  output logic      miss_valid_o,
  input  logic      miss_ready_i,
  input  lock_t     unlock_i,
  input  logic      unlock_req_i,
  input  cnt_t      cnt_down_i
);

  // tag store link
  tag_req_t tag_req;
  logic     tag_req_valid;
  logic     tag_req_ready;
  tag_res_t tag_res;
  logic     tag_res_valid;
  logic     tag_res_ready;

  // lock table and miss counters
  lock_t lock;
  logic  lock_req;
  logic  locked;
  cnt_t  cnt_up;
  logic  to_miss;
  logic  cnt_full;

  // unit state
  logic      init_q;
  logic      init_d;
  logic      busy_q;
  logic      busy_d;
  // a valid was shown and not taken yet
  logic      hold_q;
  logic      hold_miss_q;
  llc_desc_t desc_q;
  logic      load_desc;

  logic go_miss;
  logic can_send;
  logic dispatch;

  ////////////////////
  // routing
  ////////////////////
  // flushes, misses and hits behind outstanding misses take the miss path
  assign go_miss  = hold_q ? hold_miss_q : (desc_q.flush | to_miss | ~tag_res.hit);
  // once shown, the choice stays until taken
  assign can_send = busy_q & tag_res_valid & (hold_q | (~locked & ~(go_miss & cnt_full)));

  assign hit_valid_o   = can_send & ~go_miss;
  assign miss_valid_o  = can_send & go_miss;
  assign dispatch      = (hit_valid_o & hit_ready_i) | (miss_valid_o & miss_ready_i);
  assign tag_res_ready = dispatch;

  // merge the lookup result into the outgoing descriptor
  always_comb begin
    desc_o           = desc_q;
    desc_o.evict     = tag_res.evict;
    desc_o.evict_tag = tag_res.evict_tag;
    // a flush keeps its own way
    if (!desc_q.flush) begin
      desc_o.way_ind = tag_res.indicator;
      desc_o.refill  = ~tag_res.hit;
    end
  end

  ////////////////////
  // intake
  ////////////////////
  always_comb begin
    tag_req.mode      = TAG_CLEAR;
    tag_req.indicator = '1;
    tag_req.index     = '0;
    tag_req.tag       = '0;
    tag_req.dirty     = 1'b0;
    tag_req_valid     = 1'b0;
    ready_o           = 1'b0;
    load_desc         = 1'b0;
    init_d            = init_q;
    busy_d            = busy_q;
    if (!init_q) begin
      // wait out the sweep, then the clear is taken
      tag_req_valid = 1'b1;
      if (tag_req_ready) begin
        init_d = 1'b1;
      end
    end else begin
      if (dispatch) begin
        busy_d = 1'b0;
      end
      // next descriptor may enter while the current one leaves
      if (valid_i && (!busy_q || dispatch)) begin
        tag_req.mode      = desc_i.flush ? TAG_FLUSH : TAG_LOOKUP;
        tag_req.indicator = desc_i.flush ? desc_i.way_ind : '1;
        tag_req.index     = desc_i.addr[`LLC_OFFSET_W +: `LLC_IDX_W];
        tag_req.tag       = desc_i.addr[`LLC_OFFSET_W + `LLC_IDX_W +: `LLC_TAG_W];
        tag_req.dirty     = desc_i.rw;
        tag_req_valid     = 1'b1;
        if (tag_req_ready) begin
          ready_o   = 1'b1;
          load_desc = 1'b1;
          busy_d    = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      init_q      <= 1'b0;
      busy_q      <= 1'b0;
      hold_q      <= 1'b0;
      hold_miss_q <= 1'b0;
    end else begin
      init_q      <= init_d;
      busy_q      <= busy_d;
      hold_q      <= (hit_valid_o & ~hit_ready_i) | (miss_valid_o & ~miss_ready_i);
      hold_miss_q <= miss_valid_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_desc) begin
      desc_q <= desc_i;
    end
  end

  ////////////////////
  // sub-units
  ////////////////////
  llc_tag_store i_tag_store (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .req_i       ( tag_req       ),
    .req_valid_i ( tag_req_valid ),
    .req_ready_o ( tag_req_ready ),
    .res_o       ( tag_res       ),
    .res_valid_o ( tag_res_valid ),
    .res_ready_i ( tag_res_ready )
  );

  // count only what really enters the miss pipeline
  assign cnt_up.id    = desc_q.id;
  assign cnt_up.valid = ~desc_q.flush & miss_valid_o & miss_ready_i;

  llc_miss_counters i_miss_counters (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .cnt_up_i   ( cnt_up     ),
    .cnt_down_i ( cnt_down_i ),
    .query_id_i ( desc_q.id  ),
    .to_miss_o  ( to_miss    ),
    .full_o     ( cnt_full   )
  );

  // line of the descriptor in the unit, locked on any non-flush dispatch
  assign lock.index   = desc_q.addr[`LLC_OFFSET_W +: `LLC_IDX_W];
  assign lock.way_ind = desc_o.way_ind;
  assign lock_req     = ~desc_q.flush & dispatch;

  llc_lock_table i_lock_table (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .lock_i       ( lock         ),
    .lock_req_i   ( lock_req     ),
    .locked_o     ( locked       ),
    .unlock_i     ( unlock_i     ),
    .unlock_req_i ( unlock_req_i )
  );

  // a descriptor leaves on one port only
  a_one_valid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(hit_valid_o && miss_valid_o))
    else $error("hit_valid_o and miss_valid_o both high");

  // tag store result must name at most one way
  a_way_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit_valid_o || miss_valid_o) |-> $onehot0(desc_o.way_ind))
    else $error("desc_o.way_ind %h not one-hot", desc_o.way_ind);

endmodule

// File: llc_hit_miss_macros.svh
// sizing constants of the llc hit/miss stage
// include wherever a width or a count of ways, sets or ids is needed
`ifndef LLC_HIT_MISS_MACROS_SVH
`define LLC_HIT_MISS_MACROS_SVH

// set-associative geometry
`define LLC_WAYS 4
`define LLC_SETS 16

// address split into tag, index and offset
`define LLC_ADDR_W 32
`define LLC_IDX_W 4
// byte and block offset bits below the index
`define LLC_OFFSET_W 4
// whatever remains above the index
`define LLC_TAG_W (`LLC_ADDR_W - `LLC_IDX_W - `LLC_OFFSET_W)

// transaction id width, one miss counter per id
`define LLC_ID_W 2

// miss counter width, all ones means full
`define LLC_CNT_W 3

`endif

// File: llc_hit_miss_pkg.sv
// shared types of the llc hit/miss stage
// descriptor, tag store request/response, lock and count structs
`include "llc_hit_miss_macros.svh"

package llc_hit_miss_pkg;

  // operation carried out by the tag store
  typedef enum logic [1:0] {
    TAG_CLEAR  = 2'd0,
    TAG_LOOKUP = 2'd1,
    TAG_FLUSH  = 2'd2
  } tag_mode_e;

  // one-hot, one bit per way
  typedef logic [`LLC_WAYS-1:0]   way_ind_t;
  typedef logic [`LLC_IDX_W-1:0]  idx_t;
  typedef logic [`LLC_TAG_W-1:0]  tag_t;
  typedef logic [`LLC_ID_W-1:0]   id_t;
  typedef logic [`LLC_ADDR_W-1:0] addr_t;

  // descriptor flowing through the stage
  typedef struct packed {
    // set by the requester
    id_t      id;
    // 1 for a write
    logic     rw;
    addr_t    addr;
    logic     flush;
    // target way of a flush, lookup result otherwise
    way_ind_t way_ind;
    // filled in from the tag lookup
    logic     evict;
    tag_t     evict_tag;
    logic     refill;
  } llc_desc_t;

  // request into the tag store
  typedef struct packed {
    tag_mode_e mode;
    way_ind_t  indicator;
    idx_t      index;
    tag_t      tag;
    logic      dirty;
  } tag_req_t;

  // response of a lookup or flush
  typedef struct packed {
    way_ind_t indicator;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } tag_res_t;

  // names one cache line by set and way
  typedef struct packed {
    idx_t     index;
    way_ind_t way_ind;
  } lock_t;

  // counter strobe, used for both up and down
  typedef struct packed {
    id_t  id;
    logic valid;
  } cnt_t;

endpackage

// File: llc_lock_table.sv
// one lock bit per set and way, marking lines still in use downstream
// set when a descriptor is dispatched, cleared by the unlock strobe
`timescale 1ns/1ps
`include "llc_hit_miss_macros.svh"

module llc_lock_table import llc_hit_miss_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  lock_t lock_i,
  input  logic  lock_req_i,
  output logic  locked_o,
  input  lock_t unlock_i,
  input  logic  unlock_req_i
);

  way_ind_t lock_q [`LLC_SETS];
  way_ind_t lock_d [`LLC_SETS];

  // line in question is held by any of its named ways
  assign locked_o = |(lock_q[lock_i.index] & lock_i.way_ind);

  // unlock then lock, so both hit the same set without losing one
  always_comb begin
    for (int s = 0; s < `LLC_SETS; s++) begin
      lock_d[s] = lock_q[s];
    end
    if (unlock_req_i) begin
      lock_d[unlock_i.index] = lock_d[unlock_i.index] & ~unlock_i.way_ind;
    end
    if (lock_req_i) begin
      lock_d[lock_i.index] = lock_d[lock_i.index] | lock_i.way_ind;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < `LLC_SETS; s++) begin
        lock_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < `LLC_SETS; s++) begin
        lock_q[s] <= lock_d[s];
      end
    end
  end

  // downstream releases only lines it was given
  a_unlock_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    unlock_req_i |-> |(lock_q[unlock_i.index] & unlock_i.way_ind))
    else $error("unlock of free line set %h way %h", unlock_i.index, unlock_i.way_ind);

  // the stage never dispatches onto a held line
  a_lock_free : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lock_req_i |-> !locked_o)
    else $error("lock of held line set %h way %h", lock_i.index, lock_i.way_ind);

endmodule

// File: llc_miss_counters.sv
// per-id count of descriptors outstanding in the miss pipeline
// keeps hits of an id in order behind its earlier misses
`timescale 1ns/1ps
`include "llc_hit_miss_macros.svh"

module llc_miss_counters import llc_hit_miss_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  cnt_t cnt_up_i,
  input  cnt_t cnt_down_i,
  input  id_t  query_id_i,
  output logic to_miss_o,
  output logic full_o
);

  localparam int unsigned NUM_IDS = 2 ** `LLC_ID_W;

  logic [`LLC_CNT_W-1:0] cnt_q [NUM_IDS];
  logic [NUM_IDS-1:0]    up_vec;
  logic [NUM_IDS-1:0]    down_vec;

  // decode the strobes per id
  always_comb begin
    for (int i = 0; i < NUM_IDS; i++) begin
      up_vec[i]   = cnt_up_i.valid && (cnt_up_i.id == id_t'(i));
      down_vec[i] = cnt_down_i.valid && (cnt_down_i.id == id_t'(i));
    end
  end

  // up and down on the same id cancel
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        if (up_vec[i] && !down_vec[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (down_vec[i] && !up_vec[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // any outstanding miss forces the miss path
  assign to_miss_o = (cnt_q[query_id_i] != '0);
  assign full_o    = &cnt_q[query_id_i];

  // the stage must stall rather than overflow a counter
  a_no_up_when_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_up_i.valid |-> !(&cnt_q[cnt_up_i.id]))
    else $error("miss counter overflow on id %h", cnt_up_i.id);

  // downstream only returns what was sent
  a_no_down_at_zero : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_down_i.valid |-> (cnt_q[cnt_down_i.id] != '0))
    else $error("miss counter underflow on id %h", cnt_down_i.id);

endmodule

// File: llc_tag_store.sv
// tag, valid and dirty storage with lookup, replacement and flush
// clears one set per cycle after reset, then serves one request at a time
`timescale 1ns/1ps
`include "llc_hit_miss_macros.svh"

module llc_tag_store import llc_hit_miss_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  tag_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output tag_res_t res_o,
  output logic     res_valid_o,
  input  logic     res_ready_i
);

  localparam int unsigned WAY_W = $clog2(`LLC_WAYS);

  // storage arrays, cleared by the sweep and not by reset
  tag_t             tag_q   [`LLC_SETS][`LLC_WAYS];
  way_ind_t         valid_q [`LLC_SETS];
  way_ind_t         dirty_q [`LLC_SETS];
  logic [WAY_W-1:0] rr_q    [`LLC_SETS];

  // clearing sweep
  logic clear_q;
  idx_t clear_idx_q;

  // request register, arrays are read from it in the following cycle
  tag_req_t req_q;
  logic     pend_q;
  logic     req_fire;
  idx_t     rd_idx;

  tag_res_t res_q;
  logic     res_valid_q;
  tag_res_t res_d;

  // lookup results
  way_ind_t         set_valid;
  way_ind_t         set_dirty;
  way_ind_t         hit_vec;
  logic             hit;
  logic             inv_found;
  logic [WAY_W-1:0] hit_way;
  logic [WAY_W-1:0] inv_way;
  logic [WAY_W-1:0] flush_way;
  logic [WAY_W-1:0] sel_way;

  // busy while sweeping, while a read is pending or a response waits
  assign req_ready_o = ~clear_q & ~pend_q & (~res_valid_q | res_ready_i);
  assign req_fire    = req_valid_i & req_ready_o;
  assign rd_idx      = req_q.index;

  ////////////////////
  // lookup
  ////////////////////
  always_comb begin
    set_valid = valid_q[rd_idx];
    set_dirty = dirty_q[rd_idx];
    hit_vec   = '0;
    hit_way   = '0;
    inv_found = 1'b0;
    inv_way   = '0;
    flush_way = '0;
    // walk downwards so the lowest invalid way wins
    for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
      hit_vec[w] = set_valid[w] && (tag_q[rd_idx][w] == req_q.tag);
      if (hit_vec[w]) begin
        hit_way = WAY_W'(w);
      end
      if (!set_valid[w]) begin
        inv_found = 1'b1;
        inv_way   = WAY_W'(w);
      end
      if (req_q.indicator[w]) begin
        flush_way = WAY_W'(w);
      end
    end
    hit = |hit_vec;
    // flush names its way, a miss takes a free way or the round-robin victim
    if (req_q.mode == TAG_FLUSH) begin
      sel_way = flush_way;
    end else if (hit) begin
      sel_way = hit_way;
    end else if (inv_found) begin
      sel_way = inv_way;
    end else begin
      sel_way = rr_q[rd_idx];
    end
    res_d.indicator = way_ind_t'(1) << sel_way;
    res_d.hit       = hit && (req_q.mode == TAG_LOOKUP);
    // a valid dirty line that gets replaced or flushed is evicted
    res_d.evict     = ~res_d.hit & set_valid[sel_way] & set_dirty[sel_way];
    res_d.evict_tag = tag_q[rd_idx][sel_way];
  end

  ////////////////////
  // control state
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      clear_q     <= 1'b1;
      clear_idx_q <= '0;
      pend_q      <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      if (clear_q) begin
        clear_idx_q <= clear_idx_q + 1'b1;
        if (clear_idx_q == idx_t'(`LLC_SETS - 1)) begin
          clear_q <= 1'b0;
        end
      end
      pend_q <= req_fire;
      if (res_valid_q && res_ready_i) begin
        res_valid_q <= 1'b0;
      end
      // clear requests only acknowledge, they return nothing
      if (pend_q && (req_q.mode != TAG_CLEAR)) begin
        res_valid_q <= 1'b1;
      end
    end
  end

  ////////////////////
  // array update
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      req_q <= req_i;
    end
    if (pend_q) begin
      res_q <= res_d;
    end
    if (clear_q) begin
      valid_q[clear_idx_q] <= '0;
      dirty_q[clear_idx_q] <= '0;
      rr_q[clear_idx_q]    <= '0;
    end else if (pend_q) begin
      case (req_q.mode)
        TAG_LOOKUP: begin
          if (hit) begin
            // a write hit dirties the line
            if (req_q.dirty) begin
              dirty_q[rd_idx][hit_way] <= 1'b1;
            end
          end else begin
            tag_q[rd_idx][sel_way]   <= req_q.tag;
            valid_q[rd_idx][sel_way] <= 1'b1;
            dirty_q[rd_idx][sel_way] <= req_q.dirty;
            // pointer only moves when a valid line was replaced
            if (!inv_found) begin
              rr_q[rd_idx] <= rr_q[rd_idx] + 1'b1;
            end
          end
        end
        TAG_FLUSH: begin
          valid_q[rd_idx][sel_way] <= 1'b0;
          dirty_q[rd_idx][sel_way] <= 1'b0;
        end
        TAG_CLEAR: begin
          valid_q[rd_idx] <= valid_q[rd_idx] & ~req_q.indicator;
          dirty_q[rd_idx] <= dirty_q[rd_idx] & ~req_q.indicator;
        end
        default: begin
        end
      endcase
    end
  end

  assign res_o       = res_q;
  assign res_valid_o = res_valid_q;

  // the requester must name a single way when flushing
  a_flush_one_way : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_fire && (req_i.mode == TAG_FLUSH)) |-> $onehot(req_i.indicator))
    else $error("tag store flush with indicator %h", req_i.indicator);

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the llc hit/miss testbench with Verilator
# exits nonzero when the build fails, the run fails or the log reports failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert \
  --top-module tb_llc_hit_miss \
  -Mdir "$BUILD" \
  -f llc_hit_miss.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD/Vtb_llc_hit_miss" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation passed"
exit 0

// File: tb_llc_hit_miss.sv
// testbench of the llc hit/miss stage, top module tb_llc_hit_miss
// drives descriptors through the DUT and checks every output transfer against a model
`timescale 1ns/1ps
`include "llc_hit_miss_macros.svh"

module tb_llc_hit_miss import llc_hit_miss_pkg::*; ();

  localparam int NUM_IDS     = 2 ** `LLC_ID_W;
  localparam int NUM_TESTS   = 6;
  // 200 cycles per test plus reset and the clearing sweep
  localparam int WATCHDOG_NS = (NUM_TESTS * 200 + `LLC_SETS + 8) * 10;

  logic      clk_i = 1'b0;
  logic      rst_n_i;
  llc_desc_t desc_i;
  logic      valid_i;
  logic      ready_o;
  llc_desc_t desc_o;
  logic      hit_valid_o;
  logic      hit_ready_i;
  logic      miss_valid_o;
  logic      miss_ready_i;
  lock_t     unlock_i;
  logic      unlock_req_i;
  cnt_t      cnt_down_i;

  // expected outcome of the descriptor in flight
  logic      exp_armed;
  logic      exp_miss;
  llc_desc_t exp_desc;
  // high while a locked line must keep the outputs quiet
  logic      hold_line;

  // reference model state
  tag_t m_tag   [`LLC_SETS][`LLC_WAYS];
  logic m_valid [`LLC_SETS][`LLC_WAYS];
  logic m_dirty [`LLC_SETS][`LLC_WAYS];
  int   m_rr    [`LLC_SETS];
  int   m_out   [NUM_IDS];

  int          seed;
  logic [31:0] rnd_q;
  int          since_rst;
  int          err_cnt  = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          test_num = 1;
  int          test_err_start = 0;

  logic hit_xfer;
  logic miss_xfer;

  assign hit_xfer  = hit_valid_o & hit_ready_i;
  assign miss_xfer = miss_valid_o & miss_ready_i;

  always #5 clk_i = ~clk_i;

  llc_hit_miss i_dut (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .desc_i       ( desc_i       ),
    .valid_i      ( valid_i      ),
    .ready_o      ( ready_o      ),
    .desc_o       ( desc_o       ),
    .hit_valid_o  ( hit_valid_o  ),
    .hit_ready_i  ( hit_ready_i  ),
    .miss_valid_o ( miss_valid_o ),
    .miss_ready_i ( miss_ready_i ),
    .unlock_i     ( unlock_i     ),
    .unlock_req_i ( unlock_req_i ),
    .cnt_down_i   ( cnt_down_i   )
  );

  // cycles since reset release, saturating
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      since_rst <= 0;
    end else if (since_rst < 1000) begin
      since_rst <= since_rst + 1;
    end
  end

  // random back-pressure, one draw per cycle also feeds the random test
  initial begin
    seed         = 32'ha087_5462;
    rnd_q        = '0;
    hit_ready_i  = 1'b0;
    miss_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      rnd_q        = $random(seed);
      hit_ready_i  = |rnd_q[1:0];
      miss_ready_i = |rnd_q[3:2];
    end
  end

  ////////////////////
  // checks
  ////////////////////
  a_clearing : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (since_rst < `LLC_SETS) |-> (!ready_o && !hit_valid_o && !miss_valid_o))
    else begin
      err_cnt = err_cnt + 1;
      $display("ready_o or an output valid went high during the clearing sweep");
    end

  a_one_valid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(hit_valid_o && miss_valid_o))
    else begin
      err_cnt = err_cnt + 1;
      $display("hit_valid_o and miss_valid_o are high together");
    end

  a_way_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit_valid_o || miss_valid_o) |-> $onehot0(desc_o.way_ind))
    else begin
      err_cnt = err_cnt + 1;
      $display("mismatch desc_o.way_ind: %h is not one-hot", $sampled(desc_o.way_ind));
    end

  a_locked_quiet : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    hold_line |-> !(hit_valid_o || miss_valid_o))
    else begin
      err_cnt = err_cnt + 1;
      $display("an output valid rose while its line was still locked");
    end

  // a shown valid holds with a stable descriptor until taken
  a_hit_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit_valid_o && !hit_ready_i) |=> (hit_valid_o && $stable(desc_o)))
    else begin
      err_cnt = err_cnt + 1;
      $display("hit_valid_o dropped or desc_o changed before the transfer");
    end

  a_miss_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (miss_valid_o && !miss_ready_i) |=> (miss_valid_o && $stable(desc_o)))
    else begin
      err_cnt = err_cnt + 1;
      $display("miss_valid_o dropped or desc_o changed before the transfer");
    end

  a_expected : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit_xfer || miss_xfer) |-> exp_armed)
    else begin
      err_cnt = err_cnt + 1;
      $display("output transfer with no descriptor in flight");
    end

  a_port : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit_xfer || miss_xfer) |-> (miss_xfer == exp_miss))
    else begin
      err_cnt = err_cnt + 1;
      $display("mismatch miss_valid_o: got %h expected %h", $sampled(miss_xfer), exp_miss);
    end

  a_addr : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit_xfer || miss_xfer) |-> (desc_o.addr == exp_desc.addr))
    else begin
      err_cnt = err_cnt + 1;
      $display("mismatch desc_o.addr: got %h expected %h",
               $sampled(desc_o.addr), exp_desc.addr);
    end

  // requester fields pass through unchanged
  a_req_fields : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit_xfer || miss_xfer) |->
      ({desc_o.id, desc_o.rw, desc_o.flush} == {exp_desc.id, exp_desc.rw, exp_desc.flush}))
    else begin
      err_cnt = err_cnt + 1;
      $display("mismatch desc_o id, rw, flush: got %h expected %h",
               $sampled({desc_o.id, desc_o.rw, desc_o.flush}),
               {exp_desc.id, exp_desc.rw, exp_desc.flush});
    end

  a_way : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit_xfer || miss_xfer) |-> (desc_o.way_ind == exp_desc.way_ind))
    else begin
      err_cnt = err_cnt + 1;
      $display("mismatch desc_o.way_ind: got %h expected %h",
               $sampled(desc_o.way_ind), exp_desc.way_ind);
    end

  a_refill : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit_xfer || miss_xfer) |-> (desc_o.refill == exp_desc.refill))
    else begin
      err_cnt = err_cnt + 1;
      $display("mismatch desc_o.refill: got %h expected %h",
               $sampled(desc_o.refill), exp_desc.refill);
    end

  a_evict : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit_xfer || miss_xfer) |-> (desc_o.evict == exp_desc.evict))
    else begin
      err_cnt = err_cnt + 1;
      $display("mismatch desc_o.evict: got %h expected %h",
               $sampled(desc_o.evict), exp_desc.evict);
    end

  // tag only matters when a line is evicted
  a_evict_tag : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((hit_xfer || miss_xfer) && exp_desc.evict) |-> (desc_o.evict_tag == exp_desc.evict_tag))
    else begin
      err_cnt = err_cnt + 1;
      $display("mismatch desc_o.evict_tag: got %h expected %h",
               $sampled(desc_o.evict_tag), exp_desc.evict_tag);
    end

  ////////////////////
  // model and helpers
  ////////////////////
  function automatic addr_t make_addr(input tag_t tag, input idx_t set);
    return {tag, set, {`LLC_OFFSET_W{1'b0}}};
  endfunction

  // predict route and result fields, then advance the model
  task automatic predict(input llc_desc_t d);
    idx_t set;
    tag_t tag;
    int   way;
    logic hit;
    set      = d.addr[`LLC_OFFSET_W +: `LLC_IDX_W];
    tag      = d.addr[`LLC_ADDR_W-1 -: `LLC_TAG_W];
    way      = -1;
    hit      = 1'b0;
    exp_desc = d;
    if (d.flush) begin
      for (int w = 0; w < `LLC_WAYS; w++) begin
        if (d.way_ind[w]) begin
          way = w;
        end
      end
      exp_desc.evict     = m_valid[set][way] & m_dirty[set][way];
      exp_desc.evict_tag = m_tag[set][way];
      m_valid[set][way]  = 1'b0;
      m_dirty[set][way]  = 1'b0;
      exp_miss           = 1'b1;
    end else begin
      for (int w = 0; w < `LLC_WAYS; w++) begin
        if (m_valid[set][w] && m_tag[set][w] == tag) begin
          hit = 1'b1;
          way = w;
        end
      end
      if (hit) begin
        if (d.rw) begin
          m_dirty[set][way] = 1'b1;
        end
      end else begin
        // first free way counting up from way 0
        for (int w = 0; w < `LLC_WAYS; w++) begin
          if (way < 0 && !m_valid[set][w]) begin
            way = w;
          end
        end
        // set full, the round-robin victim goes
        if (way < 0) begin
          way                = m_rr[set];
          m_rr[set]          = (m_rr[set] + 1) % `LLC_WAYS;
          exp_desc.evict     = m_dirty[set][way];
          exp_desc.evict_tag = m_tag[set][way];
        end
        m_tag[set][way]   = tag;
        m_valid[set][way] = 1'b1;
        m_dirty[set][way] = d.rw;
      end
      exp_desc.way_ind = way_ind_t'(1 << way);
      exp_desc.refill  = ~hit;
      exp_miss         = ~hit | (m_out[d.id] != 0);
      if (exp_miss) begin
        m_out[d.id] = m_out[d.id] + 1;
      end
    end
  endtask

  // hand one descriptor over and wait until it leaves the stage
  task automatic send_desc(input id_t id, input logic rw, input addr_t addr, input logic flush,
                           input way_ind_t way, output logic went_miss,
                           output way_ind_t got_way);
    llc_desc_t d;
    d         = '0;
    d.id      = id;
    d.rw      = rw;
    d.addr    = addr;
    d.flush   = flush;
    d.way_ind = way;
    predict(d);
    exp_armed = 1'b1;
    desc_i    = d;
    valid_i   = 1'b1;
    do begin
      @(negedge clk_i);
    end while (!ready_o);
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;
    desc_i  = '0;
    do begin
      @(negedge clk_i);
    end while (!hit_xfer && !miss_xfer);
    went_miss = miss_valid_o;
    got_way   = desc_o.way_ind;
    @(posedge clk_i);
    #1;
    exp_armed = 1'b0;
  endtask

  // one-cycle unlock and count-down strobes
  task automatic release_line(input addr_t addr, input way_ind_t way, input id_t id,
                              input logic do_unlock, input logic do_cnt);
    unlock_i.index   = addr[`LLC_OFFSET_W +: `LLC_IDX_W];
    unlock_i.way_ind = way;
    unlock_req_i     = do_unlock;
    cnt_down_i.id    = id;
    cnt_down_i.valid = do_cnt;
    @(posedge clk_i);
    #1;
    unlock_req_i = 1'b0;
    cnt_down_i   = '0;
    if (do_cnt) begin
      m_out[id] = m_out[id] - 1;
    end
  endtask

  task automatic send_and_release(input id_t id, input logic rw, input addr_t addr,
                                  input logic flush, input way_ind_t way);
    logic     went_miss;
    way_ind_t got_way;
    send_desc(id, rw, addr, flush, way, went_miss, got_way);
    // flushes take no lock and no count
    if (!flush) begin
      release_line(addr, got_way, id, 1'b1, went_miss);
    end
  endtask

  task automatic report_test(input string name);
    if (err_cnt == test_err_start) begin
      pass_cnt = pass_cnt + 1;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      fail_cnt = fail_cnt + 1;
      $display("test %0d %s: %0d errors", test_num, name, err_cnt - test_err_start);
    end
    test_num       = test_num + 1;
    test_err_start = err_cnt;
  endtask

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    logic        went_miss;
    way_ind_t    got_way;
    way_ind_t    first_way;
    logic [31:0] r;
    addr_t       a;
    rst_n_i      = 1'b0;
    desc_i       = '0;
    valid_i      = 1'b0;
    unlock_i     = '0;
    unlock_req_i = 1'b0;
    cnt_down_i   = '0;
    hold_line    = 1'b0;
    exp_armed    = 1'b0;
    exp_miss     = 1'b0;
    exp_desc     = '0;
    for (int s = 0; s < `LLC_SETS; s++) begin
      m_rr[s] = 0;
      for (int w = 0; w < `LLC_WAYS; w++) begin
        m_tag[s][w]   = '0;
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
      end
    end
    for (int i = 0; i < NUM_IDS; i++) begin
      m_out[i] = 0;
    end
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // valid is up at once, ready must wait for the sweep
    a = make_addr(24'h0000a1, 4'd2);
    send_and_release(2'd0, 1'b0, a, 1'b0, '0);
    report_test("clear sweep then first miss");

    send_and_release(2'd0, 1'b0, a, 1'b0, '0);
    report_test("hit after release");

    // second access stays behind the first miss of id 1
    a = make_addr(24'h0000b2, 4'd3);
    send_desc(2'd1, 1'b0, a, 1'b0, '0, went_miss, first_way);
    release_line(a, first_way, 2'd1, 1'b1, 1'b0);
    send_desc(2'd1, 1'b0, a, 1'b0, '0, went_miss, got_way);
    release_line(a, got_way, 2'd1, 1'b1, 1'b1);
    release_line(a, got_way, 2'd1, 1'b0, 1'b1);
    report_test("hit behind outstanding miss");

    // line stays locked until the strobe in the second branch
    a = make_addr(24'h0000c3, 4'd4);
    send_desc(2'd2, 1'b0, a, 1'b0, '0, went_miss, first_way);
    release_line(a, first_way, 2'd2, 1'b0, 1'b1);
    hold_line = 1'b1;
    fork
      send_desc(2'd2, 1'b0, a, 1'b0, '0, went_miss, got_way);
      begin
        repeat (20) @(posedge clk_i);
        #1;
        hold_line = 1'b0;
        release_line(a, first_way, 2'd2, 1'b1, 1'b0);
      end
    join
    release_line(a, got_way, 2'd2, 1'b1, 1'b0);
    report_test("locked line stalls");

    // five dirty tags into set 5, then flush way 2 and read it back
    for (int t = 0; t < 5; t++) begin
      send_and_release(2'd3, 1'b1, make_addr(tag_t'(32'hd0 + t), 4'd5), 1'b0, '0);
    end
    send_and_release(2'd3, 1'b0, make_addr('0, 4'd5), 1'b1, 4'b0100);
    send_and_release(2'd3, 1'b0, make_addr(24'h0000d2, 4'd5), 1'b0, '0);
    report_test("eviction and flush");

    // small tag pool on two sets keeps hits, evictions and flushes coming
    for (int n = 0; n < 12; n++) begin
      @(negedge clk_i);
      r = rnd_q;
      @(posedge clk_i);
      #1;
      a = make_addr(tag_t'(r[25:23]), {3'b100, r[26]});
      send_and_release(r[21:20], r[22], a, (r[29:27] == 3'd0), way_ind_t'(1) << r[31:30]);
    end
    report_test("random traffic");

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule
